// ==== sources.f ====
src/crc_pkg.sv
src/store_pkg.sv
src/crc_byte_step.sv
src/crc_engine.sv
src/crc_channel.sv
src/result_arbiter.sv
src/result_store.sv
src/crc_subsys_top.sv
dv/tb_clk_gen.sv
dv/crc_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CRC subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module crc_subsys_tb -f sources.f \
    --Mdir obj_dir -o crc_subsys_sim \
    && out="$(./obj_dir/crc_subsys_sim)" \
    && printf '%s\n' "$out" \
    && grep -qx "STATUS: PASS" <<< "$out" \
    && echo "Simulation passed" \
    || { echo "Simulation failed" >&2; exit 1; }

// ==== dv/crc_subsys_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_subsys_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int RAND_FRAMES = 40;  // Per channel
    localparam int WD_FRAMES   = 200; // Watchdog budget
    localparam int WD_CYCLES   = 20;  // Cycles allowed per frame
    localparam logic [31:0] POLY_REFL = 32'hEDB8_8320; // 0x04C11DB7 bit reversed

    logic                            clk;
    logic                            rst_n;
    logic                            drv_valid [2];
    logic                            drv_sof [2];
    logic                            drv_eof [2];
    logic [crc_pkg::BYTES-1:0]       drv_be [2];
    logic [crc_pkg::DATA_W-1:0]      drv_data [2];
    logic [store_pkg::NUM_CHAN-1:0]  ready;
    logic                            rd_en;
    logic [store_pkg::ADDR_W-1:0]    rd_addr;
    logic [crc_pkg::CRC_W-1:0]       rd_crc;
    logic [store_pkg::LEN_W-1:0]     rd_len;

    ////////////////////////////////////////
    // Store model, one ring per channel
    logic [store_pkg::SLOT_W-1:0]    slot_model [2];
    logic [crc_pkg::CRC_W-1:0]       ring_crc [2][store_pkg::SLOTS_PER_CHAN];
    logic [store_pkg::LEN_W-1:0]     ring_len [2][store_pkg::SLOTS_PER_CHAN];
    logic [store_pkg::ADDR_W-1:0]    pend_addr [$]; // Records waiting for readback
    logic [crc_pkg::CRC_W-1:0]       pend_crc [$];
    logic [store_pkg::LEN_W-1:0]     pend_len [$];
    bit                              chan_done [2];
    int crc_errs, len_errs, ready_errs, other_errs;

    tb_clk_gen #(.PERIOD_NS (CLK_PERIOD), .RESET_CYCLES (3)) u_clk_gen (
        .o_clk (clk), .o_rst_n (rst_n)
    );

    crc_subsys_top crc_subsys_top_i (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_valid ({drv_valid[1], drv_valid[0]}),
        .i_sof ({drv_sof[1], drv_sof[0]}),
        .i_eof ({drv_eof[1], drv_eof[0]}),
        .i_be_0 (drv_be[0]), .i_be_1 (drv_be[1]),
        .i_data_0 (drv_data[0]), .i_data_1 (drv_data[1]),
        .o_ready (ready),
        .i_rd_en (rd_en), .i_rd_addr (rd_addr),
        .o_rd_crc (rd_crc), .o_rd_len (rd_len)
    );

    // Reflected CRC-32, one byte LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    // Contiguous enables from lane 0
    function automatic logic [3:0] be_of_width(input int w);
        return 4'((1 << w) - 1);
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    task automatic check_crc(input logic [crc_pkg::CRC_W-1:0] got,
                             input logic [crc_pkg::CRC_W-1:0] exp, input string what);
        if (got !== exp) begin
            crc_errs++;
            $display("MISMATCH %0t ns: %s crc 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input logic [store_pkg::LEN_W-1:0] got,
                             input logic [store_pkg::LEN_W-1:0] exp, input string what);
        if (got !== exp) begin
            len_errs++;
            $display("MISMATCH %0t ns: %s len %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic [store_pkg::NUM_CHAN-1:0] got,
                               input logic [store_pkg::NUM_CHAN-1:0] exp, input string what);
        if (got !== exp) begin
            ready_errs++;
            $display("MISMATCH %0t ns: %s ready %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Host read, data sampled one falling edge after the request
    task automatic check_record(input logic [store_pkg::ADDR_W-1:0] addr,
                                input logic [crc_pkg::CRC_W-1:0] exp_crc,
                                input logic [store_pkg::LEN_W-1:0] exp_len, input string what);
        @(negedge clk);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en = 1'b0;
        check_crc(rd_crc, exp_crc, $sformatf("%s, addr %0d", what, addr));
        check_len(rd_len, exp_len, $sformatf("%s, addr %0d", what, addr));
    endtask

    ////////////////////////////////////////
    // Frame driver and record prediction
    task automatic send_frame(input int ch, input int n_words, input logic [3:0] last_be,
                              input logic [31:0] words [8],
                              output logic [store_pkg::ADDR_W-1:0] addr,
                              output logic [31:0] exp_crc, output logic [15:0] exp_len);
        logic [31:0] crc_v;
        logic [3:0]  be_v;
        logic [1:0]  slot_v;
        crc_v   = 32'hFFFF_FFFF; // Every frame starts from the preset
        exp_len = '0;
        for (int w = 0; w < n_words; w++) begin
            be_v = (w == n_words - 1) ? last_be : 4'b1111;
            @(negedge clk);
            while (!ready[ch]) begin
                @(negedge clk);
            end
            drv_valid[ch] = 1'b1;
            drv_sof[ch]   = (w == 0);
            drv_eof[ch]   = (w == n_words - 1);
            drv_be[ch]    = be_v;
            drv_data[ch]  = words[w];
            for (int b = 0; b < 4; b++) begin
                if (be_v[b]) begin
                    crc_v   = crc_byte(crc_v, words[w][b*8 +: 8]); // Lane 0 first
                    exp_len = exp_len + 1'b1;
                end
            end
        end
        @(negedge clk);
        drv_valid[ch] = 1'b0;
        drv_sof[ch]   = 1'b0;
        drv_eof[ch]   = 1'b0;
        // Ready comes back once the record is in the store
        while (!ready[ch]) begin
            @(negedge clk);
        end
        slot_v               = slot_model[ch];
        exp_crc              = crc_v ^ 32'hFFFF_FFFF;
        addr                 = {1'(ch), slot_v};
        ring_crc[ch][slot_v] = exp_crc;
        ring_len[ch][slot_v] = exp_len;
        slot_model[ch]       = slot_v + 1'b1; // Wraps after slot 3
    endtask

    task automatic run_random_frames(input int ch);
        logic [31:0]                  words [8];
        logic [store_pkg::ADDR_W-1:0] addr;
        logic [31:0]                  crc;
        logic [15:0]                  len;
        int                           n_words;
        for (int f = 0; f < RAND_FRAMES; f++) begin
            n_words = 1 + int'($urandom % 8);
            for (int w = 0; w < 8; w++) begin
                words[w] = $urandom;
            end
            send_frame(ch, n_words, be_of_width(1 + int'($urandom % 4)), words, addr, crc, len);
            pend_addr.push_back(addr);
            pend_crc.push_back(crc);
            pend_len.push_back(len);
            repeat (int'($urandom % 3)) begin
                @(negedge clk); // Idle gap between frames
            end
        end
        chan_done[ch] = 1'b1;
    endtask

    // Reads back each record soon after it lands, long before its slot wraps
    task automatic drain_reads();
        while (!(chan_done[0] && chan_done[1]) || pend_addr.size() > 0) begin
            if (pend_addr.size() == 0) begin
                @(negedge clk);
            end else begin
                check_record(pend_addr.pop_front(), pend_crc.pop_front(), pend_len.pop_front(),
                             "random frame");
            end
        end
    endtask

    task automatic finish_run();
        $display("Errors: crc %0d, len %0d, ready %0d, other %0d",
                 crc_errs, len_errs, ready_errs, other_errs);
        if (crc_errs + len_errs + ready_errs + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Test sequence
    initial begin : main
        logic [31:0]                  words_a [8];
        logic [31:0]                  words_b [8];
        logic [store_pkg::ADDR_W-1:0] addr_a, addr_b;
        logic [31:0]                  crc_a, crc_b;
        logic [15:0]                  len_a, len_b;
        for (int ch = 0; ch < 2; ch++) begin
            drv_valid[ch]  = 1'b0;
            drv_sof[ch]    = 1'b0;
            drv_eof[ch]    = 1'b0;
            drv_be[ch]     = '0;
            drv_data[ch]   = '0;
            slot_model[ch] = '0;
            chan_done[ch]  = 1'b0;
            for (int s = 0; s < store_pkg::SLOTS_PER_CHAN; s++) begin
                ring_crc[ch][s] = '0; // Unwritten slots read as zero
                ring_len[ch][s] = '0;
            end
        end
        rd_en   = 1'b0;
        rd_addr = '0;
        void'($urandom(32'hbc2c_3feb));
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_ready(ready, 2'b11, "after reset");
        for (int a = 0; a < 8; a++) begin
            check_record(3'(a), '0, '0, "empty store");
        end
        // "123456789", little-endian words
        words_a[0] = 32'h3433_3231;
        words_a[1] = 32'h3837_3635;
        words_a[2] = 32'h0000_0039;
        send_frame(0, 3, 4'b0001, words_a, addr_a, crc_a, len_a);
        check_record(addr_a, 32'hCBF4_3926, 16'd9, "check vector");
        // Two word frames on both channels, eof in the same cycle
        for (int w = 0; w < 8; w++) begin
            words_a[w] = $urandom;
            words_b[w] = $urandom;
        end
        fork
            send_frame(0, 2, 4'b0111, words_a, addr_a, crc_a, len_a);
            send_frame(1, 2, 4'b0011, words_b, addr_b, crc_b, len_b);
        join
        check_record(addr_a, crc_a, len_a, "simultaneous eof ch0");
        check_record(addr_b, crc_b, len_b, "simultaneous eof ch1");
        fork
            run_random_frames(0);
            run_random_frames(1);
            drain_reads();
        join
        // Newest four records per channel
        for (int ch = 0; ch < 2; ch++) begin
            for (int s = 0; s < store_pkg::SLOTS_PER_CHAN; s++) begin
                check_record({1'(ch), 2'(s)}, ring_crc[ch][s], ring_len[ch][s], "ring sweep");
            end
        end
        finish_run();
    end

    initial begin : watchdog
        #(WD_FRAMES * WD_CYCLES * CLK_PERIOD);
        other_errs++;
        $display("Timeout: run did not finish within %0d frames of %0d cycles",
                 WD_FRAMES, WD_CYCLES);
        finish_run();
    end

endmodule : crc_subsys_tb

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1; // Release away from the rising edge
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule : tb_clk_gen

`default_nettype wire

// ==== src/crc_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_subsys_top (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic [store_pkg::NUM_CHAN-1:0] i_valid,
    input  wire logic [store_pkg::NUM_CHAN-1:0] i_sof,
    input  wire logic [store_pkg::NUM_CHAN-1:0] i_eof,
    input  wire logic [crc_pkg::BYTES-1:0]      i_be_0,
    input  wire logic [crc_pkg::BYTES-1:0]      i_be_1,
    input  wire logic [crc_pkg::DATA_W-1:0]     i_data_0,
    input  wire logic [crc_pkg::DATA_W-1:0]     i_data_1,
    output logic      [store_pkg::NUM_CHAN-1:0] o_ready,
    input  wire logic                           i_rd_en,
    input  wire logic [store_pkg::ADDR_W-1:0]   i_rd_addr,
    output logic      [crc_pkg::CRC_W-1:0]      o_rd_crc,
    output logic      [store_pkg::LEN_W-1:0]    o_rd_len
);

    ////////////////////////////////////////
    // Channel to engine
    logic [store_pkg::NUM_CHAN-1:0] first;
    logic [store_pkg::NUM_CHAN-1:0] load;
    logic [crc_pkg::BYTES-1:0]      sel_0, sel_1;
    logic [crc_pkg::CRC_W-1:0]      crc_0, crc_1;   // Engine results

    ////////////////////////////////////////
    // Channel to arbiter
    logic [store_pkg::NUM_CHAN-1:0] req;
    logic [store_pkg::NUM_CHAN-1:0] gnt;
    logic [store_pkg::SLOT_W-1:0]   addr_0, addr_1;
    logic [crc_pkg::CRC_W-1:0]      rec_crc_0, rec_crc_1;
    logic [store_pkg::LEN_W-1:0]    rec_len_0, rec_len_1;

    // Arbiter to store
    logic                           wr_en;
    logic [store_pkg::ADDR_W-1:0]   wr_addr;
    logic [crc_pkg::CRC_W-1:0]      wr_crc;
    logic [store_pkg::LEN_W-1:0]    wr_len;

    crc_channel u_chan_0 (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_valid (i_valid[0]), .i_sof (i_sof[0]), .i_eof (i_eof[0]),
        .i_be (i_be_0), .i_crc (crc_0), .i_gnt (gnt[0]),
        .o_ready (o_ready[0]), .o_first (first[0]), .o_load (load[0]),
        .o_cascade_sel (sel_0), .o_req (req[0]), .o_addr (addr_0),
        .o_rec_crc (rec_crc_0), .o_rec_len (rec_len_0)
    );

    crc_channel u_chan_1 (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_valid (i_valid[1]), .i_sof (i_sof[1]), .i_eof (i_eof[1]),
        .i_be (i_be_1), .i_crc (crc_1), .i_gnt (gnt[1]),
        .o_ready (o_ready[1]), .o_first (first[1]), .o_load (load[1]),
        .o_cascade_sel (sel_1), .o_req (req[1]), .o_addr (addr_1),
        .o_rec_crc (rec_crc_1), .o_rec_len (rec_len_1)
    );

    // Data words go straight to the engines
    crc_engine u_engine_0 (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_first (first[0]), .i_load (load[0]),
        .i_cascade_sel (sel_0), .i_data (i_data_0), .o_crc (crc_0)
    );

    crc_engine u_engine_1 (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_first (first[1]), .i_load (load[1]),
        .i_cascade_sel (sel_1), .i_data (i_data_1), .o_crc (crc_1)
    );

    result_arbiter u_arb (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_req (req),
        .i_addr_0 (addr_0), .i_addr_1 (addr_1),
        .i_crc_0 (rec_crc_0), .i_crc_1 (rec_crc_1),
        .i_len_0 (rec_len_0), .i_len_1 (rec_len_1),
        .o_gnt (gnt), .o_wr_en (wr_en), .o_wr_addr (wr_addr),
        .o_wr_crc (wr_crc), .o_wr_len (wr_len)
    );

    result_store u_store (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_crc (wr_crc), .i_wr_len (wr_len),
        .i_rd_en (i_rd_en), .i_rd_addr (i_rd_addr),
        .o_rd_crc (o_rd_crc), .o_rd_len (o_rd_len)
    );

endmodule : crc_subsys_top

`default_nettype wire

// ==== src/result_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_store (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_wr_en,
    input  wire logic [store_pkg::ADDR_W-1:0] i_wr_addr,
    input  wire logic [crc_pkg::CRC_W-1:0]    i_wr_crc,
    input  wire logic [store_pkg::LEN_W-1:0]  i_wr_len,
    input  wire logic                         i_rd_en,
    input  wire logic [store_pkg::ADDR_W-1:0] i_rd_addr,
    output logic      [crc_pkg::CRC_W-1:0]    o_rd_crc,
    output logic      [store_pkg::LEN_W-1:0]  o_rd_len
);

    logic [crc_pkg::CRC_W-1:0]   mem_crc [store_pkg::NUM_CHAN*store_pkg::SLOTS_PER_CHAN];
    logic [store_pkg::LEN_W-1:0] mem_len [store_pkg::NUM_CHAN*store_pkg::SLOTS_PER_CHAN];
    logic [store_pkg::NUM_CHAN*store_pkg::SLOTS_PER_CHAN-1:0] written_q; // Entry holds a record

    // Record array, contents undefined until written
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem_crc[i_wr_addr] <= i_wr_crc;
            mem_len[i_wr_addr] <= i_wr_len;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            written_q <= '0;
        end else if (i_wr_en) begin
            written_q[i_wr_addr] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Host read, one cycle latency
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_crc <= '0;
            o_rd_len <= '0;
        end else if (i_rd_en) begin
            if (written_q[i_rd_addr]) begin
                o_rd_crc <= mem_crc[i_rd_addr];
                o_rd_len <= mem_len[i_rd_addr];
            end else begin
                o_rd_crc <= '0; // Empty slot reads as zero
                o_rd_len <= '0;
            end
        end
    end

endmodule : result_store

`default_nettype wire

// ==== src/result_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_arbiter (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic [store_pkg::NUM_CHAN-1:0] i_req,
    input  wire logic [store_pkg::SLOT_W-1:0]   i_addr_0,
    input  wire logic [store_pkg::SLOT_W-1:0]   i_addr_1,
    input  wire logic [crc_pkg::CRC_W-1:0]      i_crc_0,
    input  wire logic [crc_pkg::CRC_W-1:0]      i_crc_1,
    input  wire logic [store_pkg::LEN_W-1:0]    i_len_0,
    input  wire logic [store_pkg::LEN_W-1:0]    i_len_1,
    output logic      [store_pkg::NUM_CHAN-1:0] o_gnt,
    output logic                                o_wr_en,
    output logic      [store_pkg::ADDR_W-1:0]   o_wr_addr,
    output logic      [crc_pkg::CRC_W-1:0]      o_wr_crc,
    output logic      [store_pkg::LEN_W-1:0]    o_wr_len
);

    logic last_q;   // Channel granted most recently
    logic gnt_idx;  // Channel granted now

    // Combinational round robin
    always_comb begin
        case (i_req)
            2'b01:   o_gnt = 2'b01;
            2'b10:   o_gnt = 2'b10;
            2'b11:   o_gnt = last_q ? 2'b01 : 2'b10; // Skip last winner
            default: o_gnt = 2'b00;
        endcase
    end

    assign gnt_idx = o_gnt[1];
    assign o_wr_en = |o_gnt;

    ////////////////////////////////////////
    // Write port steering
    assign o_wr_addr = {gnt_idx, gnt_idx ? i_addr_1 : i_addr_0}; // Channel, then slot
    assign o_wr_crc  = gnt_idx ? i_crc_1 : i_crc_0;
    assign o_wr_len  = gnt_idx ? i_len_1 : i_len_0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_q <= 1'b1; // Channel 0 wins the first tie
        end else if (o_wr_en) begin
            last_q <= gnt_idx;
        end
    end

endmodule : result_arbiter

`default_nettype wire

// ==== src/crc_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_channel (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_valid,
    input  wire logic                         i_sof,
    input  wire logic                         i_eof,
    input  wire logic [crc_pkg::BYTES-1:0]    i_be,          // Contiguous from lane 0
    input  wire logic [crc_pkg::CRC_W-1:0]    i_crc,         // From engine output flop
    input  wire logic                         i_gnt,         // Store write this edge
    output logic                              o_ready,
    output logic                              o_first,
    output logic                              o_load,
    output logic      [crc_pkg::BYTES-1:0]    o_cascade_sel,
    output logic                              o_req,
    output logic      [store_pkg::SLOT_W-1:0] o_addr,        // Write slot in the ring
    output logic      [crc_pkg::CRC_W-1:0]    o_rec_crc,
    output logic      [store_pkg::LEN_W-1:0]  o_rec_len
);

    store_pkg::chan_state_e        state_q;
    logic [store_pkg::SLOT_W-1:0]  slot_q;     // Next slot to fill
    logic [store_pkg::LEN_W-1:0]   len_q;      // Bytes so far in frame
    logic [store_pkg::LEN_W-1:0]   word_bytes; // Bytes in the current word
    logic                          accept;

    // Source may only drive while taking words
    assign o_ready = (state_q == store_pkg::CH_IDLE) || (state_q == store_pkg::CH_FRAME);

    // Stray words outside a frame are dropped
    assign accept = i_valid && o_ready && (i_sof || state_q == store_pkg::CH_FRAME);

    assign o_load  = accept;
    assign o_first = accept && i_sof;

    ////////////////////////////////////////
    // Byte enable decode
    always_comb begin
        for (int i = 0; i < crc_pkg::BYTES - 1; i++) begin
            o_cascade_sel[i] = i_be[i] && !i_be[i+1]; // Top of the enabled run
        end
        o_cascade_sel[crc_pkg::BYTES-1] = i_be[crc_pkg::BYTES-1];
    end

    always_comb begin
        word_bytes = '0;
        for (int i = 0; i < crc_pkg::BYTES; i++) begin
            if (i_be[i]) begin
                word_bytes = word_bytes + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= store_pkg::CH_IDLE;
            len_q   <= '0;
            o_req   <= 1'b0;
            slot_q  <= '0;
        end else begin
            case (state_q)
                store_pkg::CH_IDLE, store_pkg::CH_FRAME: begin
                    if (accept) begin
                        len_q   <= i_sof ? word_bytes : len_q + word_bytes; // sof restarts
                        state_q <= i_eof ? store_pkg::CH_SETTLE : store_pkg::CH_FRAME;
                    end
                end
                store_pkg::CH_SETTLE: begin
                    state_q <= store_pkg::CH_POST; // Engine flop valid next edge
                end
                store_pkg::CH_POST: begin
                    if (!o_req) begin
                        o_req <= 1'b1;            // CRC captured this edge
                    end else if (i_gnt) begin
                        o_req   <= 1'b0;
                        state_q <= store_pkg::CH_IDLE;
                        if (int'(slot_q) == store_pkg::SLOTS_PER_CHAN - 1) begin
                            slot_q <= '0;         // Ring wrap
                        end else begin
                            slot_q <= slot_q + 1'b1;
                        end
                    end
                end
                default: state_q <= store_pkg::CH_IDLE;
            endcase
        end
    end

    // Record payload, held until granted
    always_ff @(posedge i_clk) begin
        if (state_q == store_pkg::CH_POST && !o_req) begin
            o_rec_crc <= i_crc;
        end
    end

    assign o_rec_len = len_q;  // Frozen while not accepting
    assign o_addr    = slot_q;

endmodule : crc_channel

`default_nettype wire

// ==== src/crc_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_engine (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_first,       // Seed chain from CRC_INIT
    input  wire logic                       i_load,        // Word accepted
    input  wire logic [crc_pkg::BYTES-1:0]  i_cascade_sel, // One-hot, highest live byte
    input  wire logic [crc_pkg::DATA_W-1:0] i_data,        // Little-endian word
    output logic      [crc_pkg::CRC_W-1:0]  o_crc
);

    logic [crc_pkg::CRC_W-1:0] crc_q;                       // Running register
    logic [7:0]                blk [crc_pkg::BYTES];        // Per-lane bytes
    logic [crc_pkg::CRC_W-1:0] tap [crc_pkg::BYTES+1];      // tap[0] is the chain seed
    logic [crc_pkg::CRC_W-1:0] sel_crc;                     // Chosen chain output
    logic [crc_pkg::CRC_W-1:0] crc_out;                     // Reflected register
    logic [crc_pkg::CRC_W-1:0] crc_fin;                     // After final XOR

    ////////////////////////////////////////
    // Input byte ordering
    generate
        for (genvar i = 0; i < crc_pkg::BYTES; i++) begin : g_lane
            if (crc_pkg::REFLECT_IN) begin : g_refl
                for (genvar j = 0; j < 8; j++) begin : g_bit
                    assign blk[i][j] = i_data[i*8 + 7 - j]; // Swap bits in byte
                end
            end else begin : g_direct
                assign blk[i] = i_data[i*8 +: 8];
            end
        end
    endgenerate

    ////////////////////////////////////////
    // Byte cascade, lane 0 first
    assign tap[0] = i_first ? crc_pkg::CRC_INIT : crc_q; // New frame restarts

    generate
        for (genvar i = 0; i < crc_pkg::BYTES; i++) begin : g_chain
            crc_byte_step u_step (
                .i_crc_in  (tap[i]),
                .i_byte    (blk[i]),
                .o_crc_out (tap[i+1])
            );
        end
    endgenerate

    // Pick the stage after the last enabled byte
    always_comb begin
        sel_crc = crc_q; // No lane marked, hold
        for (int i = 0; i < crc_pkg::BYTES; i++) begin
            if (i_cascade_sel[i]) begin
                sel_crc = tap[i+1];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= '0;
        end else if (i_load) begin
            crc_q <= sel_crc; // One word per load
        end
    end

    ////////////////////////////////////////
    // Output path
    generate
        if (crc_pkg::REFLECT_OUT) begin : g_refl_out
            for (genvar k = 0; k < crc_pkg::CRC_W; k++) begin : g_bit
                assign crc_out[k] = crc_q[crc_pkg::CRC_W - 1 - k];
            end
        end else begin : g_direct_out
            assign crc_out = crc_q;
        end
    endgenerate

    assign crc_fin = crc_out ^ crc_pkg::CRC_XOR_OUT;

    // One edge behind the running register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else begin
            o_crc <= crc_fin;
        end
    end

endmodule : crc_engine

`default_nettype wire

// ==== src/crc_byte_step.sv ====
`timescale 1ns/1ns
`default_nettype none

// One byte through the CRC LFSR, eight shifts unrolled
module crc_byte_step (
    input  wire logic [crc_pkg::CRC_W-1:0] i_crc_in,
    input  wire logic [7:0]                i_byte,   // Already bit-reflected
    output logic      [crc_pkg::CRC_W-1:0] o_crc_out
);

    always_comb begin : p_step
        logic [crc_pkg::CRC_W-1:0] crc_v;
        logic                      fb;

        crc_v = i_crc_in;
        fb    = 1'b0;
        // MSB of the reflected byte is the first bit on the wire
        for (int b = 7; b >= 0; b--) begin
            fb    = crc_v[crc_pkg::CRC_W-1] ^ i_byte[b]; // Feedback tap
            crc_v = {crc_v[crc_pkg::CRC_W-2:0], 1'b0};    // Shift up
            if (fb) begin
                crc_v = crc_v ^ crc_pkg::CRC_POLY;        // Fold in generator
            end
        end
        o_crc_out = crc_v;
    end

endmodule : crc_byte_step

`default_nettype wire

// ==== src/store_pkg.sv ====
`default_nettype none

package store_pkg;

    ////////////////////////////////////////
    // Result memory geometry
    localparam int NUM_CHAN       = 2;  // Peer channels sharing the store
    localparam int SLOTS_PER_CHAN = 4;  // Ring of records per channel
    localparam int SLOT_W         = 2;  // Slot index bits
    localparam int ADDR_W         = 3;  // {channel, slot}
    localparam int LEN_W          = 16; // Frame byte count

    ////////////////////////////////////////
    // Per-channel FSM
    typedef enum logic [1:0] {
        CH_IDLE   = 2'd0, // Waiting for a sof word
        CH_FRAME  = 2'd1, // Inside a frame
        CH_SETTLE = 2'd2, // Engine output flop catching up
        CH_POST   = 2'd3  // Record captured, requesting the store
    } chan_state_e;

endpackage : store_pkg

`default_nettype wire

// ==== src/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

    ////////////////////////////////////////
    // Data path widths
    localparam int DATA_W = 32;         // Input word width
    localparam int BYTES  = DATA_W / 8; // Byte lanes per word
    localparam int CRC_W  = 32;         // Checksum width

    ////////////////////////////////////////
    // Ethernet CRC-32, reflected form

    // Normal (MSB first) form of the generator
    localparam logic [CRC_W-1:0] CRC_POLY    = 32'h04C1_1DB7;
    localparam logic [CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF; // Preset all ones
    localparam logic [CRC_W-1:0] CRC_XOR_OUT = 32'hFFFF_FFFF; // Final inversion

    // Bit order of each input byte is swapped before the LFSR
    localparam logic REFLECT_IN  = 1'b1;
    // Whole register is swapped on the way out
    localparam logic REFLECT_OUT = 1'b1;

endpackage : crc_pkg

`default_nettype wire
